// File: dv/rx_offset_cal_tests.svh
/* Directed tests of the offset calibration block and the
   expected trim code derived from the comparator thresholds */

  // Floor of the mean of the rising and falling thresholds
  function automatic int expected_code(input int lane);
    return (int'(thr_hi[lane]) + int'(thr_lo[lane])) / 2;
  endfunction

  task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge sys_clk);
    cfg_wr    = 1'b0;
  endtask

  task automatic wait_cal_clear(input int limit);
    int n;
    n = 0;
    while (cal_done !== 1'b0 && n < limit) begin
      @(negedge sys_clk);
      n++;
    end
    if (cal_done !== 1'b0) begin
      $display("cal_done did not clear within %0d cycles of start_cal falling", limit);
      err_cnt++;
    end
  endtask

  task automatic check_codes_fixed(input int exp);
    for (int i = 0; i < `LANE_COUNT; i++)
      check_value($sformatf("lane %0d code", i), 32'(offs_cal_code[i]), 32'(exp));
  endtask

  task automatic check_codes_last();
    for (int i = 0; i < `LANE_COUNT; i++)
      check_value($sformatf("lane %0d code", i), 32'(offs_cal_code[i]), 32'(last_exp[i]));
  endtask

  // Lanes must be idle, start_cal is left high afterwards
  task automatic run_calibration(input int min_cyc, input int max_cyc);
    int cycles;
    draw_thresholds();
    for (int i = 0; i < `LANE_COUNT; i++) last_exp[i] = expected_code(i);
    @(negedge sys_clk);
    start_cal = 1'b1;
    cycles    = 0;
    while (cal_done !== 1'b1) begin   // Run timeout bounds this wait
      @(negedge sys_clk);
      cycles++;
    end
    if (cycles < min_cyc || cycles > max_cyc) begin
      $display("FAIL at time %0t: sweep took %0d cycles, expected %0d to %0d",
               $time, cycles, min_cyc, max_cyc);
      err_cnt++;
    end
    check_codes_last();
  endtask

  task automatic check_reset_values();
    int err_start;
    err_start = err_cnt;
    check_value("cal_done", 32'(cal_done), 32'd0);
    check_value("div_ld_ack", 32'(div_ld_ack), 32'd0);
    check_codes_fixed(0);
    finish_test("reset_values", err_start);
  endtask

  task automatic calibrate_div1();
    int err_start;
    err_start = err_cnt;
    run_calibration(60, 80);          // 67 steps at full rate
    finish_test("calibrate_div1", err_start);
  endtask

  task automatic switch_div4_and_calibrate();
    int err_start;
    int ack_cnt;
    int ack_pos;
    err_start = err_cnt;
    start_cal = 1'b0;
    wait_cal_clear(1);                // One cal_clk period at DIV1
    repeat (2) @(negedge sys_clk);
    write_reg(`REG_DIV_SEL, 8'(cal_cfg_pkg::DIV4));
    ack_cnt = 0;
    ack_pos = -1;
    for (int c = 0; c < 8; c++) begin
      @(negedge sys_clk);
      if (div_ld_ack === 1'b1) begin
        ack_cnt++;
        if (ack_pos < 0) ack_pos = c;
      end
    end
    check_value("div_ld_ack pulse count", 32'(ack_cnt), 32'd1);
    check_value("div_ld_ack cycle after load", 32'(ack_pos), 32'd1);  // Second edge after div_ld
    run_calibration(240, 300);
    finish_test("switch_div4_and_calibrate", err_start);
  endtask

  task automatic check_override();
    int err_start;
    err_start = err_cnt;
    write_reg(`REG_OVRD_CODE, 8'd19);
    write_reg(`REG_OVRD_CTRL, 8'h01);   // Select, done forced low
    check_codes_fixed(19);
    check_value("cal_done with done_ovrd 0", 32'(cal_done), 32'd0);
    write_reg(`REG_OVRD_CTRL, 8'h03);
    check_codes_fixed(19);
    check_value("cal_done with done_ovrd 1", 32'(cal_done), 32'd1);
    write_reg(`REG_OVRD_CTRL, 8'h00);
    check_codes_last();
    check_value("cal_done after override", 32'(cal_done), 32'd1);
    finish_test("override", err_start);
  endtask

  task automatic check_scan_mode();
    int err_start;
    err_start = err_cnt;
    scan_mode = 1'b1;
    @(negedge sys_clk);
    check_codes_fixed(0);
    write_reg(`REG_OVRD_CTRL, 8'h03);
    check_codes_fixed(0);
    write_reg(`REG_OVRD_CTRL, 8'h00);
    check_codes_fixed(0);
    scan_mode = 1'b0;
    @(negedge sys_clk);
    check_codes_last();
    finish_test("scan_mode", err_start);
  endtask

  task automatic restart_calibration();
    int err_start;
    err_start = err_cnt;
    start_cal = 1'b0;
    wait_cal_clear(4);                // One cal_clk period at DIV4
    check_codes_fixed(0);
    write_reg(`REG_OVRD_CTRL, 8'h03);   // Lanes idle, only the override raises done
    check_value("cal_done forced with lanes idle", 32'(cal_done), 32'd1);
    write_reg(`REG_OVRD_CTRL, 8'h00);
    check_value("cal_done released with lanes idle", 32'(cal_done), 32'd0);
    repeat (4) @(negedge sys_clk);
    run_calibration(240, 300);
    finish_test("restart_calibration", err_start);
  endtask

// File: dv/rx_offset_cal_tb.sv
/* Offset calibration testbench top: clock and reset, hysteretic comparator
   model, LFSR thresholds, timeout and the closing report */
`timescale 1ns/1ps
`include "rx_cal_settings.svh"

module rx_offset_cal_tb;

  localparam int TIMEOUT_CYCLES = 4000;   // 6 calibrations x 70 x 8, plus margin

  logic                                    sys_clk = 1'b0;
  logic                                    rst_n;
  logic                                    cfg_wr;
  logic [1:0]                              cfg_addr;
  logic [7:0]                              cfg_wdata;
  logic                                    start_cal;
  logic                                    scan_mode;
  logic [`LANE_COUNT-1:0]                  ana_rxdata = '0;
  logic                                    cal_done;
  logic [`LANE_COUNT-1:0][`CAL_CODE_W-1:0] offs_cal_code;
  logic                                    div_ld_ack;

  logic [`CAL_CODE_W-1:0] thr_lo [`LANE_COUNT];
  logic [`CAL_CODE_W-1:0] thr_hi [`LANE_COUNT];
  int                     last_exp [`LANE_COUNT];  // Expected codes of the last sweep
  logic [31:0]            lfsr_state;
  int                     cycle_cnt = 0;
  int                     err_cnt;
  int                     tests_run;
  int                     tests_failed;

  rx_offset_cal_top dut_i (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .cfg_wr        (cfg_wr),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .start_cal     (start_cal),
    .scan_mode     (scan_mode),
    .ana_rxdata    (ana_rxdata),
    .cal_done      (cal_done),
    .offs_cal_code (offs_cal_code),
    .div_ld_ack    (div_ld_ack)
  );

  always #50 sys_clk = ~sys_clk;   // 100 ns period

  // Comparator with hysteresis per lane, driven on the falling edge
  always @(negedge sys_clk) begin
    for (int i = 0; i < `LANE_COUNT; i++) begin
      if (offs_cal_code[i] >= thr_hi[i]) ana_rxdata[i] <= 1'b1;
      else if (offs_cal_code[i] < thr_lo[i]) ana_rxdata[i] <= 1'b0;
    end
  end

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: cal_done never arrived within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ==============================
  // Random thresholds
  // ==============================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h80200003;   // Galois taps
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      val        = {val[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Keeps 1 <= thr_lo <= thr_hi <= 31
  task automatic draw_thresholds();
    logic [7:0] a;
    logic [7:0] b;
    for (int i = 0; i < `LANE_COUNT; i++) begin
      take_bits(`CAL_CODE_W, a);
      take_bits(`CAL_CODE_W, b);
      a = (a % 8'd31) + 8'd1;
      b = (b % 8'd31) + 8'd1;
      thr_lo[i] = (a < b) ? a[`CAL_CODE_W-1:0] : b[`CAL_CODE_W-1:0];
      thr_hi[i] = (a < b) ? b[`CAL_CODE_W-1:0] : a[`CAL_CODE_W-1:0];
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (err_cnt == err_start) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, err_cnt - err_start);
    end
  endtask

  `include "rx_offset_cal_tests.svh"

  initial begin
    rst_n        = 1'b0;
    cfg_wr       = 1'b0;
    cfg_addr     = 2'd0;
    cfg_wdata    = 8'h00;
    start_cal    = 1'b0;
    scan_mode    = 1'b0;
    lfsr_state   = 32'h5ea977bb;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < `LANE_COUNT; i++) begin
      thr_lo[i]   = 5'd1;
      thr_hi[i]   = 5'd31;
      last_exp[i] = 0;
    end
    repeat (16) @(posedge sys_clk);
    @(negedge sys_clk);
    rst_n = 1'b1;

    check_reset_values();
    calibrate_div1();
    switch_div4_and_calibrate();
    check_override();
    check_scan_mode();
    restart_calibration();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: hdl/cal_cfg_pkg.sv
/* Configuration types: calibration clock ratio enum and
   the software override struct */
`include "rx_cal_settings.svh"

package cal_cfg_pkg;

  // Calibration clock ratio, encoded as log2 of the divide
  typedef enum logic [1:0] {
    DIV1 = 2'd0,
    DIV2 = 2'd1,
    DIV4 = 2'd2,
    DIV8 = 2'd3
  } clk_div_sel_e;

  // Software override, applied to every lane at once
  typedef struct packed {
    logic                   ovrd_sel;   // Select override over lane results
    logic                   done_ovrd;  // Forced done flag
    logic [`CAL_CODE_W-1:0] code_ovrd;  // Forced trim code
  } cal_ovrd_t;

endpackage

// File: hdl/cal_clk_div.sv
/* Calibration clock generator, divide by 1/2/4/8 from sys_clk,
   with scan bypass and a load acknowledge pulse */
`timescale 1ns/1ps

module cal_clk_div (
  input  logic                      sys_clk,
  input  logic                      rst_n,
  input  logic                      scan_mode,
  input  cal_cfg_pkg::clk_div_sel_e div_sel,
  input  logic                      div_ld,
  output logic                      cal_clk,
  output logic                      div_ld_ack
);

  logic [2:0]                cnt;       // Free running divide counter
  logic                      ld_stg;    // First apply stage
  cal_cfg_pkg::clk_div_sel_e div_pend;  // Ratio captured with div_ld
  cal_cfg_pkg::clk_div_sel_e div_act;   // Ratio in use
  logic                      div_clk;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= 3'd0;
    end else begin
      cnt <= cnt + 3'd1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (div_ld) begin
      div_pend <= div_sel;
    end
  end

  // ==============================
  // Two stage ratio apply
  // ==============================
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      ld_stg     <= 1'b0;
      div_act    <= cal_cfg_pkg::DIV1;
      div_ld_ack <= 1'b0;
    end else begin
      ld_stg     <= div_ld;
      div_ld_ack <= ld_stg;                  // Rises with the new ratio
      if (ld_stg) begin
        div_act <= div_pend;
      end
    end
  end

  // Counter bit n toggles every 2^n sys_clk cycles
  always_comb begin
    case (div_act)
      cal_cfg_pkg::DIV2: div_clk = cnt[0];
      cal_cfg_pkg::DIV4: div_clk = cnt[1];
      cal_cfg_pkg::DIV8: div_clk = cnt[2];
      default:           div_clk = sys_clk;
    endcase
  end

  assign cal_clk = scan_mode ? sys_clk : div_clk;

endmodule

// File: hdl/cal_lane_pkg.sv
/* Lane types: sweep state enum and per-lane result struct */
`include "rx_cal_settings.svh"

package cal_lane_pkg;

  typedef enum logic [2:0] {
    CAL_IDLE = 3'd0,
    CAL_UP   = 3'd1,   // Code counts up from zero
    CAL_ROLL = 3'd2,   // Single hold step at full scale
    CAL_DOWN = 3'd3,   // Code counts back down to zero
    CAL_DONE = 3'd4
  } cal_state_e;

  typedef struct packed {
    logic                   done;
    logic [`CAL_CODE_W-1:0] code;
  } lane_result_t;

endpackage

// File: hdl/cal_ovrd_regs.sv
/* Override and divider ratio registers written by plain strobes,
   with a load pulse towards the clock divider */
`timescale 1ns/1ps
`include "rx_cal_settings.svh"

module cal_ovrd_regs (
  input  logic                      sys_clk,
  input  logic                      rst_n,
  input  logic                      cfg_wr,
  input  logic [1:0]                cfg_addr,
  input  logic [7:0]                cfg_wdata,
  output cal_cfg_pkg::cal_ovrd_t    ovrd,
  output cal_cfg_pkg::clk_div_sel_e div_sel,
  output logic                      div_ld
);

  // ==============================
  // Register write decode
  // ==============================
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      ovrd    <= '0;
      div_sel <= cal_cfg_pkg::DIV1;
      div_ld  <= 1'b0;
    end else begin
      div_ld <= 1'b0;                        // Single cycle pulse
      if (cfg_wr) begin
        case (cfg_addr)
          `REG_OVRD_CTRL: begin
            ovrd.ovrd_sel  <= cfg_wdata[0];
            ovrd.done_ovrd <= cfg_wdata[1];
          end
          `REG_OVRD_CODE: begin
            ovrd.code_ovrd <= cfg_wdata[`CAL_CODE_W-1:0];
          end
          `REG_DIV_SEL: begin
            div_sel <= cal_cfg_pkg::clk_div_sel_e'(cfg_wdata[1:0]);
            div_ld  <= 1'b1;                 // Tell divider a new ratio is waiting
          end
          default: begin
            div_ld <= 1'b0;                  // Unmapped address, write ignored
          end
        endcase
      end
    end
  end

endmodule

// File: hdl/offset_cal_lane.sv
/* Per-lane offset sweep engine: up sweep, roll step, down sweep,
   records both comparator toggle codes and outputs their mean */
`timescale 1ns/1ps
`include "rx_cal_settings.svh"

module offset_cal_lane (
  input  logic                       cal_clk,
  input  logic                       rst_n,
  input  logic                       start_cal,
  input  logic                       cal_data,
  output cal_lane_pkg::lane_result_t result
);

  localparam logic [`CAL_CODE_W-1:0] CODE_MIN = '0;
  localparam logic [`CAL_CODE_W-1:0] CODE_MAX = '1;

  cal_lane_pkg::cal_state_e state;
  cal_lane_pkg::cal_state_e state_nxt;
  logic [`CAL_CODE_W-1:0]   code;        // Code under test
  logic                     done;
  logic [1:0]               hist;        // [0] newest sample, [1] one before
  logic [`CAL_CODE_W-1:0]   code_smp;    // Code that hist[0] was taken at
  logic [`CAL_CODE_W-1:0]   up_code;
  logic [`CAL_CODE_W-1:0]   dn_code;
  logic [`CAL_CODE_W-1:0]   dn_code_nxt;
  logic                     up_found;
  logic                     dn_found;
  logic                     toggle;
  logic                     dn_chk;
  logic                     dn_hit;
  logic [`CAL_CODE_W:0]     code_sum;

  always_comb begin
    state_nxt = state;
    case (state)
      cal_lane_pkg::CAL_IDLE:
        if (start_cal) state_nxt = cal_lane_pkg::CAL_UP;
      cal_lane_pkg::CAL_UP:
        if (code == CODE_MAX) state_nxt = cal_lane_pkg::CAL_ROLL;
      cal_lane_pkg::CAL_ROLL:
        state_nxt = cal_lane_pkg::CAL_DOWN;
      cal_lane_pkg::CAL_DOWN:
        if (code == CODE_MIN) state_nxt = cal_lane_pkg::CAL_DONE;
      cal_lane_pkg::CAL_DONE:
        if (!start_cal) state_nxt = cal_lane_pkg::CAL_IDLE;
      default:
        state_nxt = cal_lane_pkg::CAL_IDLE;
    endcase
  end

  // ==============================
  // Sample history
  // ==============================
  // Comparison runs one step behind the sweep, so the change is tagged
  // with the code the newer sample was taken at
  always_ff @(posedge cal_clk) begin
    if (state == cal_lane_pkg::CAL_IDLE) begin
      hist     <= {cal_data, cal_data};      // No toggle on the first up step
      code_smp <= code;
    end else if (state != cal_lane_pkg::CAL_DONE) begin
      hist     <= {hist[0], cal_data};
      code_smp <= code;
    end
  end

  assign toggle = hist[0] ^ hist[1];

  // Last down sample (code 0) is only compared on the first stop step
  assign dn_chk      = (state == cal_lane_pkg::CAL_DOWN) ||
                       (state == cal_lane_pkg::CAL_DONE && !done);
  assign dn_hit      = dn_chk && toggle && !dn_found;
  assign dn_code_nxt = dn_hit ? code_smp + 1'b1 : dn_code;
  assign code_sum    = {1'b0, up_code} + {1'b0, dn_code_nxt};

  // ==============================
  // Sweep and result
  // ==============================
  always_ff @(posedge cal_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= cal_lane_pkg::CAL_IDLE;
      code     <= CODE_MIN;
      done     <= 1'b0;
      up_code  <= '0;
      dn_code  <= '0;
      up_found <= 1'b0;
      dn_found <= 1'b0;
    end else begin
      state <= state_nxt;
      case (state)
        cal_lane_pkg::CAL_IDLE: begin
          code     <= CODE_MIN;
          done     <= 1'b0;
          up_code  <= '0;                    // Stays 0 if never toggling
          dn_code  <= '0;
          up_found <= 1'b0;
          dn_found <= 1'b0;
        end
        cal_lane_pkg::CAL_UP, cal_lane_pkg::CAL_ROLL: begin
          if (toggle && !up_found) begin     // Keep the first rising code
            up_code  <= code_smp;
            up_found <= 1'b1;
          end
          if (state == cal_lane_pkg::CAL_UP && code != CODE_MAX) begin
            code <= code + 1'b1;
          end
        end
        cal_lane_pkg::CAL_DOWN: begin
          dn_code <= dn_code_nxt;
          if (dn_hit) begin
            dn_found <= 1'b1;
          end
          if (code != CODE_MIN) begin
            code <= code - 1'b1;
          end
        end
        cal_lane_pkg::CAL_DONE: begin
          if (!start_cal) begin
            done <= 1'b0;
            code <= CODE_MIN;
          end else if (!done) begin
            dn_code <= dn_code_nxt;
            code    <= code_sum[`CAL_CODE_W:1];   // Floor of the mean
            done    <= 1'b1;
          end
        end
        default: begin
          code <= CODE_MIN;
          done <= 1'b0;
        end
      endcase
    end
  end

  assign result.done = done;
  assign result.code = code;

endmodule

// File: hdl/rx_cal_settings.svh
/* Lane count, trim code width and the 2-bit register map
   of the receiver offset calibration block */
`ifndef RX_CAL_SETTINGS_SVH
`define RX_CAL_SETTINGS_SVH

`define LANE_COUNT    8      // Number of lane engines
`define CAL_CODE_W    5      // Comparator offset trim code width

// Register addresses
`define REG_OVRD_CTRL 2'd0   // bit 0 ovrd_sel, bit 1 done_ovrd
`define REG_OVRD_CODE 2'd1   // Forced trim code
`define REG_DIV_SEL   2'd2   // Calibration clock ratio

`endif

// File: hdl/rx_offset_cal_fsm.sv
/* Calibration controller: clock divider, lane engines,
   override and scan muxing, done merge */
`timescale 1ns/1ps
`include "rx_cal_settings.svh"

module rx_offset_cal_fsm (
  input  logic                                      sys_clk,
  input  logic                                      rst_n,
  input  logic                                      start_cal,
  input  logic                                      scan_mode,
  input  logic [`LANE_COUNT-1:0]                    ana_rxdata,
  input  cal_cfg_pkg::cal_ovrd_t                    ovrd,
  input  cal_cfg_pkg::clk_div_sel_e                 div_sel,
  input  logic                                      div_ld,
  output logic                                      cal_done,
  output logic [`LANE_COUNT-1:0][`CAL_CODE_W-1:0]   offs_cal_code,
  output logic                                      div_ld_ack
);

  logic                                           cal_clk;
  cal_lane_pkg::lane_result_t [`LANE_COUNT-1:0]   lane_res;
  logic [`LANE_COUNT-1:0]                         lane_done;

  // ==============================
  // Calibration clock
  // ==============================
  cal_clk_div u_clk_div (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .scan_mode  (scan_mode),
    .div_sel    (div_sel),
    .div_ld     (div_ld),
    .cal_clk    (cal_clk),
    .div_ld_ack (div_ld_ack)
  );

  // ==============================
  // Lane engines
  // ==============================
  genvar i;
  generate
    for (i = 0; i < `LANE_COUNT; i++) begin : g_lane
      offset_cal_lane u_lane (
        .cal_clk   (cal_clk),
        .rst_n     (rst_n),
        .start_cal (start_cal),
        .cal_data  (ana_rxdata[i]),
        .result    (lane_res[i])
      );

      assign lane_done[i] = lane_res[i].done;

      // Scan wins over override, override wins over the lane
      assign offs_cal_code[i] = scan_mode     ? '0 :
                                ovrd.ovrd_sel ? ovrd.code_ovrd : lane_res[i].code;
    end
  endgenerate

  assign cal_done = ovrd.ovrd_sel ? ovrd.done_ovrd : &lane_done;

endmodule

// File: hdl/rx_offset_cal_top.sv
/* Offset calibration top: register block and calibration controller */
`timescale 1ns/1ps
`include "rx_cal_settings.svh"

module rx_offset_cal_top (
  input  logic                                      sys_clk,
  input  logic                                      rst_n,
  input  logic                                      cfg_wr,
  input  logic [1:0]                                cfg_addr,
  input  logic [7:0]                                cfg_wdata,
  input  logic                                      start_cal,
  input  logic                                      scan_mode,
  input  logic [`LANE_COUNT-1:0]                    ana_rxdata,
  output logic                                      cal_done,
  output logic [`LANE_COUNT-1:0][`CAL_CODE_W-1:0]   offs_cal_code,
  output logic                                      div_ld_ack
);

  cal_cfg_pkg::cal_ovrd_t    ovrd;
  cal_cfg_pkg::clk_div_sel_e div_sel;
  logic                      div_ld;   // One cycle after a ratio write

  cal_ovrd_regs u_regs (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .ovrd      (ovrd),
    .div_sel   (div_sel),
    .div_ld    (div_ld)
  );

  rx_offset_cal_fsm u_cal (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .start_cal     (start_cal),
    .scan_mode     (scan_mode),
    .ana_rxdata    (ana_rxdata),
    .ovrd          (ovrd),
    .div_sel       (div_sel),
    .div_ld        (div_ld),
    .cal_done      (cal_done),
    .offs_cal_code (offs_cal_code),
    .div_ld_ack    (div_ld_ack)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the offset calibration testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f rx_offset_cal_top.f \
  --top-module rx_offset_cal_tb -o rx_offset_cal_sim

out=$(./obj_dir/rx_offset_cal_sim)
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"

// File: rx_offset_cal_top.f
+incdir+hdl
+incdir+dv
hdl/cal_cfg_pkg.sv
hdl/cal_lane_pkg.sv
hdl/cal_ovrd_regs.sv
hdl/cal_clk_div.sv
hdl/offset_cal_lane.sv
hdl/rx_offset_cal_fsm.sv
hdl/rx_offset_cal_top.sv
dv/rx_offset_cal_tb.sv
